//--- Makefile
VERILATOR ?= verilator
TOP       ?= alut_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+rtl
rtl/alut_frame_pkg.sv
rtl/alut_ctrl_pkg.sv
rtl/alut_mem_if.sv
rtl/alut_reg_bank.sv
rtl/alut_table.sv
rtl/alut_addr_checker.sv
rtl/alut_age_checker.sv
rtl/alut_top.sv
tests/alut_asserts.sv
tests/alut_monitor.sv
tests/alut_tb.sv

//--- rtl/alut_addr_checker.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_addr_checker import alut_frame_pkg::*, alut_ctrl_pkg::*;
(
   input  logic       pclk18,
   input  logic       n_p_reset18,
   input  cmd_t       command,
   input  mac_addr_t  d_addr,
   input  mac_addr_t  s_addr,
   input  port_t      s_port,
   input  mac_addr_t  mac_addr,
   input  time_t      curr_time,
   input  logic       clear_reused,
   output logic       add_check_active,
   output dport_t     d_port,
   output logic       reused,
   output mac_addr_t  lst_inv_addr_nrm,
   output port_t      lst_inv_port_nrm,
   alut_mem_if.client mem
);

   chk_state_t state;
   tbl_idx_t   d_idx;
   tbl_idx_t   s_idx;
   logic       hit;
   logic       collide;
   logic [3:0] src_mask;
   dport_t     lookup_port;

   assign d_idx = d_addr[`AL_IDX_BITS-1:0];
   assign s_idx = s_addr[`AL_IDX_BITS-1:0];

   // dest slot in LOOKUP, source slot in LEARN
   assign mem.rd_idx = (state == CHK_LOOKUP) ? d_idx : s_idx;

   assign hit      = mem.rd_entry.valid && (mem.rd_entry.mac == d_addr);
   assign collide  = mem.rd_entry.valid && (mem.rd_entry.mac != s_addr);
   assign src_mask = 4'b0001 << s_port;

   // --------------------
   // destination rule
   always_comb
   begin
      if (d_addr == mac_addr)
         lookup_port = 5'b10000;                            // for the switch
      else if (hit)
         lookup_port = {1'b0, 4'b0001 << mem.rd_entry.port};  // known port
      else
         lookup_port = {1'b0, ~src_mask};                   // flood, not back
   end

   // learn source, stamped with current time
   assign mem.wr_en    = (state == CHK_LEARN);
   assign mem.wr_idx   = s_idx;
   assign mem.wr_entry = tbl_entry_t'{valid: 1'b1, mac: s_addr, port: s_port,
                                      stamp: curr_time};

   assign add_check_active = (state != CHK_IDLE);

   // --------------------
   // FSM, two busy cycles per check
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         state  <= CHK_IDLE;
         d_port <= '0;
         reused <= 1'b0;
      end
      else
      begin
         case (state)
            CHK_IDLE :
            begin
               if (clear_reused)
                  reused <= 1'b0;  // sw ack via status read
               if (command == CMD_CHECK)
                  state <= CHK_LOOKUP;
            end
            CHK_LOOKUP :
            begin
               d_port <= lookup_port;
               state  <= CHK_LEARN;
            end
            CHK_LEARN :
            begin
               if (collide)
                  reused <= 1'b1;  // sticky until cleared
               state <= CHK_IDLE;
            end
            default : state <= CHK_IDLE;
         endcase
      end
   end

   // entry evicted by the learn write
   always_ff @(posedge pclk18)
   begin
      if (state == CHK_LEARN && collide)
      begin
         lst_inv_addr_nrm <= mem.rd_entry.mac;
         lst_inv_port_nrm <= mem.rd_entry.port;
      end
   end

endmodule

//--- rtl/alut_age_checker.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_age_checker import alut_frame_pkg::*, alut_ctrl_pkg::*;
(
   input  logic       pclk18,
   input  logic       n_p_reset18,
   input  cmd_t       command,
   input  logic [7:0] div_clk,
   input  time_t      best_bfr_age,
   output time_t      curr_time,
   output logic       age_check_active,
   output logic       inval_in_prog,
   output mac_addr_t  lst_inv_addr_cmd,
   output port_t      lst_inv_port_cmd,
   alut_mem_if.client mem
);

   age_state_t state;
   tbl_idx_t   idx;      // sweep pointer
   logic [7:0] pre_cnt;  // prescaler
   time_t      age;
   logic       stale;

   // --------------------
   // time base, one tick per div_clk+1 clocks
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         pre_cnt   <= '0;
         curr_time <= '0;
      end
      else if (pre_cnt >= div_clk)  // >= covers a lowered divider
      begin
         pre_cnt   <= '0;
         curr_time <= curr_time + time_t'(1);
      end
      else
         pre_cnt <= pre_cnt + 8'd1;
   end

   // age check on the slot under the pointer
   assign mem.rd_idx = idx;
   assign age        = curr_time - mem.rd_entry.stamp;  // wraps, unsigned
   assign stale      = (state == AGE_SWEEP) && mem.rd_entry.valid &&
                       (age > best_bfr_age);

   // write back with valid dropped
   assign mem.wr_en    = stale;
   assign mem.wr_idx   = idx;
   assign mem.wr_entry = tbl_entry_t'{valid: 1'b0, mac: mem.rd_entry.mac,
                                      port: mem.rd_entry.port,
                                      stamp: mem.rd_entry.stamp};

   // report to reg bank in the same cycle
   assign inval_in_prog    = stale;
   assign lst_inv_addr_cmd = mem.rd_entry.mac;
   assign lst_inv_port_cmd = mem.rd_entry.port;

   assign age_check_active = (state == AGE_SWEEP);

   // --------------------
   // sweep FSM, one index per cycle
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         state <= AGE_IDLE;
         idx   <= '0;
      end
      else
      begin
         case (state)
            AGE_IDLE :
            begin
               idx <= '0;
               if (command == CMD_AGE)
                  state <= AGE_SWEEP;
            end
            AGE_SWEEP :
            begin
               idx <= idx + tbl_idx_t'(1);
               if (idx == tbl_idx_t'(`AL_NUM_ENTRIES - 1))
                  state <= AGE_IDLE;  // last slot done
            end
            default : state <= AGE_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/alut_ctrl_pkg.sv
package alut_ctrl_pkg;

   // command register encoding, 3 is a no-op
   typedef enum logic [1:0]
   {
      CMD_NONE  = 2'd0,
      CMD_CHECK = 2'd1,
      CMD_AGE   = 2'd2
   } cmd_t;

   // address checker FSM
   typedef enum logic [1:0]
   {
      CHK_IDLE,
      CHK_LOOKUP,  // dest lookup
      CHK_LEARN    // source learn
   } chk_state_t;

   // age checker FSM
   typedef enum logic {AGE_IDLE, AGE_SWEEP} age_state_t;

endpackage

//--- rtl/alut_defines.svh
`ifndef ALUT_DEFINES_SVH
`define ALUT_DEFINES_SVH

// register map, 7-bit byte offsets
`define AL_FRM_D_ADDR_L   7'h00  // dest addr [31:0]
`define AL_FRM_D_ADDR_U   7'h04  // dest addr [47:32]
`define AL_FRM_S_ADDR_L   7'h08  // src addr [31:0]
`define AL_FRM_S_ADDR_U   7'h0C  // src addr [47:32]
`define AL_S_PORT         7'h10
`define AL_D_PORT         7'h14  // read only
`define AL_MAC_ADDR_L     7'h18  // switch own address
`define AL_MAC_ADDR_U     7'h1C
`define AL_CUR_TIME       7'h20  // read only
`define AL_BB_AGE         7'h24
`define AL_DIV_CLK        7'h28
`define AL_STATUS         7'h2C  // read only
`define AL_LST_INV_ADDR_L 7'h30  // read only
`define AL_LST_INV_ADDR_U 7'h34  // read only
`define AL_LST_INV_PORT   7'h38  // read only
`define AL_COMMAND        7'h3C  // write only, self clearing

// learning table geometry
`define AL_NUM_ENTRIES    8
`define AL_IDX_BITS       3

`define AL_BB_AGE_RST     32'hFFFF_FFFF  // never ages out by default

`endif

//--- rtl/alut_frame_pkg.sv
`include "alut_defines.svh"

package alut_frame_pkg;

   // widths that mean something on the frame side
   typedef logic [47:0] mac_addr_t;
   typedef logic [1:0]  port_t;     // one of four switch ports
   typedef logic [4:0]  dport_t;    // [3:0] port mask, [4] to switch itself
   typedef logic [31:0] time_t;     // prescaled ticks

   typedef logic [`AL_IDX_BITS-1:0] tbl_idx_t;  // low mac bits

   // one learning table slot
   typedef struct packed
   {
      logic      valid;
      mac_addr_t mac;
      port_t     port;
      time_t     stamp;  // time of last learn
   } tbl_entry_t;

endpackage

//--- rtl/alut_mem_if.sv
`timescale 1ns/1ps

// one client port into the learning table
interface alut_mem_if import alut_frame_pkg::*; ();

   tbl_idx_t   rd_idx;    // combinational read address
   tbl_entry_t rd_entry;  // read data, same cycle
   logic       wr_en;     // write lands at next edge
   tbl_idx_t   wr_idx;
   tbl_entry_t wr_entry;

   // checker side
   modport client
   (
      output rd_idx, wr_en, wr_idx, wr_entry,
      input  rd_entry
   );

   // table side
   modport tbl
   (
      input  rd_idx, wr_en, wr_idx, wr_entry,
      output rd_entry
   );

endinterface

//--- rtl/alut_reg_bank.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_reg_bank import alut_frame_pkg::*, alut_ctrl_pkg::*;
(
   input  logic        pclk18,
   input  logic        n_p_reset18,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   input  time_t       curr_time,
   input  logic        add_check_active,
   input  logic        age_check_active,
   input  logic        inval_in_prog,
   input  logic        reused,
   input  dport_t      d_port,
   input  mac_addr_t   lst_inv_addr_nrm,  // overwritten by learning
   input  port_t       lst_inv_port_nrm,
   input  mac_addr_t   lst_inv_addr_cmd,  // removed by aging
   input  port_t       lst_inv_port_cmd,
   output mac_addr_t   mac_addr,
   output mac_addr_t   d_addr,
   output mac_addr_t   s_addr,
   output port_t       s_port,
   output time_t       best_bfr_age,
   output logic [7:0]  div_clk,
   output cmd_t        command,
   output logic [31:0] prdata,
   output logic        clear_reused
);

   logic      read_enable;
   logic      write_enable;
   logic      active;
   cmd_t      wr_cmd;
   mac_addr_t lst_inv_addr;
   port_t     lst_inv_port;

   assign read_enable  = psel & ~penable & ~pwrite;  // setup phase
   assign write_enable = psel & penable & pwrite;    // access phase
   assign active       = add_check_active | age_check_active;
   assign wr_cmd       = cmd_t'(pwdata[1:0]);

   // status read while idle acks the reused flag
   assign clear_reused = read_enable & (paddr == `AL_STATUS) & ~active;

   // --------------------
   // read mux, data valid in access phase
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
         prdata <= '0;
      else if (read_enable)
      begin
         case (paddr)
            `AL_FRM_D_ADDR_L   : prdata <= d_addr[31:0];
            `AL_FRM_D_ADDR_U   : prdata <= {16'd0, d_addr[47:32]};
            `AL_FRM_S_ADDR_L   : prdata <= s_addr[31:0];
            `AL_FRM_S_ADDR_U   : prdata <= {16'd0, s_addr[47:32]};
            `AL_S_PORT         : prdata <= {30'd0, s_port};
            `AL_D_PORT         : prdata <= {27'd0, d_port};
            `AL_MAC_ADDR_L     : prdata <= mac_addr[31:0];
            `AL_MAC_ADDR_U     : prdata <= {16'd0, mac_addr[47:32]};
            `AL_CUR_TIME       : prdata <= curr_time;
            `AL_BB_AGE         : prdata <= best_bfr_age;
            `AL_DIV_CLK        : prdata <= {24'd0, div_clk};
            `AL_STATUS         : prdata <= {29'd0, reused, inval_in_prog, active};
            `AL_LST_INV_ADDR_L : prdata <= lst_inv_addr[31:0];
            `AL_LST_INV_ADDR_U : prdata <= {16'd0, lst_inv_addr[47:32]};
            `AL_LST_INV_PORT   : prdata <= {30'd0, lst_inv_port};
            default            : prdata <= '0;  // unmapped, command
         endcase
      end
      else
         prdata <= '0;  // zero outside access phase
   end

   // --------------------
   // writable registers
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         d_addr       <= '0;
         s_addr       <= '0;
         s_port       <= '0;
         mac_addr     <= '0;
         best_bfr_age <= `AL_BB_AGE_RST;
         div_clk      <= '0;
      end
      else if (write_enable)
      begin
         case (paddr)
            `AL_FRM_D_ADDR_L : d_addr[31:0]    <= pwdata;
            `AL_FRM_D_ADDR_U : d_addr[47:32]   <= pwdata[15:0];
            `AL_FRM_S_ADDR_L : s_addr[31:0]    <= pwdata;
            `AL_FRM_S_ADDR_U : s_addr[47:32]   <= pwdata[15:0];
            `AL_S_PORT       : s_port          <= pwdata[1:0];
            `AL_MAC_ADDR_L   : mac_addr[31:0]  <= pwdata;
            `AL_MAC_ADDR_U   : mac_addr[47:32] <= pwdata[15:0];
            `AL_BB_AGE       : best_bfr_age    <= pwdata;
            `AL_DIV_CLK      : div_clk         <= pwdata[7:0];
            default          : ;  // read only or command
         endcase
      end
   end

   // command strobe, one cycle wide
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
         command <= CMD_NONE;
      else if (command != CMD_NONE)
         command <= CMD_NONE;  // auto clear
      else if (write_enable && (paddr == `AL_COMMAND) && !active &&
               (wr_cmd == CMD_CHECK || wr_cmd == CMD_AGE))
         command <= wr_cmd;    // busy writes dropped
   end

   // --------------------
   // last invalidated entry, learning overwrite wins over aging
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;  // aged entry this cycle
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

endmodule

//--- rtl/alut_table.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_table import alut_frame_pkg::*;
(
   input logic     pclk18,
   input logic     n_p_reset18,
   alut_mem_if.tbl chk,  // address checker
   alut_mem_if.tbl age   // age checker
);

   tbl_entry_t entries [`AL_NUM_ENTRIES];

   // async reads, one per client
   assign chk.rd_entry = entries[chk.rd_idx];
   assign age.rd_entry = entries[age.rd_idx];

   // --------------------
   // writes, clients never busy together so no arbitration
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         for (int i = 0; i < `AL_NUM_ENTRIES; i++)
         begin
            entries[i] <= '0;  // all invalid
         end
      end
      else
      begin
         if (chk.wr_en)
            entries[chk.wr_idx] <= chk.wr_entry;  // learn
         if (age.wr_en)
            entries[age.wr_idx] <= age.wr_entry;  // invalidate
      end
   end

endmodule

//--- rtl/alut_top.sv
`timescale 1ns/1ps

module alut_top import alut_frame_pkg::*, alut_ctrl_pkg::*;
(
   input  logic        pclk18,
   input  logic        n_p_reset18,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   mac_addr_t  mac_addr;
   mac_addr_t  d_addr;
   mac_addr_t  s_addr;
   port_t      s_port;
   time_t      best_bfr_age;
   time_t      curr_time;
   logic [7:0] div_clk;
   cmd_t       command;
   logic       clear_reused;
   logic       add_check_active;
   logic       age_check_active;
   logic       inval_in_prog;
   logic       reused;
   dport_t     d_port;
   mac_addr_t  lst_inv_addr_nrm;
   port_t      lst_inv_port_nrm;
   mac_addr_t  lst_inv_addr_cmd;
   port_t      lst_inv_port_cmd;

   // table ports, one per checker
   alut_mem_if chk_mem ();
   alut_mem_if age_mem ();

   alut_reg_bank i_reg_bank (.*);

   alut_table i_table
   (
      .pclk18      (pclk18),
      .n_p_reset18 (n_p_reset18),
      .chk         (chk_mem),
      .age         (age_mem)
   );

   alut_addr_checker i_addr_checker (.*, .mem(chk_mem));

   alut_age_checker i_age_checker (.*, .mem(age_mem));

endmodule

//--- tests/alut_asserts.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_asserts import alut_ctrl_pkg::*;
(
   input logic        pclk18,
   input logic        n_p_reset18,
   input logic        psel,
   input logic        penable,
   input logic        pwrite,
   input logic [6:0]  paddr,
   input logic [31:0] pwdata,
   input cmd_t        command,
   input logic        add_check_active,
   input logic        age_check_active,
   input logic [31:0] prdata
);

   int   fails = 0;  // read by the testbench at the end
   logic rd_setup;
   logic cmd_wr;

   assign rd_setup = psel & ~penable & ~pwrite;  // apb setup phase of a read
   assign cmd_wr   = psel & penable & pwrite & (paddr == `AL_COMMAND);

   // --------------------
   // command strobe is a single pulse, right after a command write
   cmd_one_cycle : assert property (@(posedge pclk18) disable iff (!n_p_reset18)
      (command != CMD_NONE) |-> ($past(command) == CMD_NONE) && $past(cmd_wr) &&
                                (command == cmd_t'($past(pwdata[1:0]))))
   else
   begin
      fails++;
      $error("command strobe held longer than one cycle or not caused by a write");
   end

   // table has one writer at a time
   one_checker : assert property (@(posedge pclk18) disable iff (!n_p_reset18)
      !(add_check_active && age_check_active))
   else
   begin
      fails++;
      $error("address checker and age checker active together");
   end

   // read data only right after a setup phase
   prdata_idle_zero : assert property (@(posedge pclk18) disable iff (!n_p_reset18)
      !$past(rd_setup) |-> (prdata == '0))
   else
   begin
      fails++;
      $error("prdata nonzero without a preceding read");
   end

endmodule

bind alut_reg_bank alut_asserts reg_asserts
(
   .pclk18           (pclk18),
   .n_p_reset18      (n_p_reset18),
   .psel             (psel),
   .penable          (penable),
   .pwrite           (pwrite),
   .paddr            (paddr),
   .pwdata           (pwdata),
   .command          (command),
   .add_check_active (add_check_active),
   .age_check_active (age_check_active),
   .prdata           (prdata)
);

//--- tests/alut_monitor.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_monitor import alut_frame_pkg::*, alut_ctrl_pkg::*;
(
   input  logic        pclk18,
   input  logic        n_p_reset18,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] prdata,
   output int          errors,
   output int          checks
);

   // register model
   mac_addr_t  m_d;
   mac_addr_t  m_s;
   mac_addr_t  m_mac;
   port_t      m_sp;
   time_t      m_bb;
   logic [7:0] m_div;
   cmd_t       m_cmd;
   dport_t     m_dport;
   logic       m_reused;
   mac_addr_t  m_lst_addr;
   port_t      m_lst_port;
   mac_addr_t  m_nrm_addr;  // last entry evicted by learning
   port_t      m_nrm_port;
   // checker, table and time model
   int         chk_ph;      // 0 idle, 1 lookup, 2 learn
   logic       age_on;
   tbl_idx_t   age_i;
   time_t      tcnt;
   logic [7:0] pcnt;
   tbl_entry_t m_tbl [`AL_NUM_ENTRIES];
   tbl_entry_t e;
   // pending read
   logic       pend;
   logic [31:0] exp_rd;
   logic [6:0] exp_addr;
   logic       active;
   logic       inv_now;
   logic       rd_setup;
   logic       wr_acc;

   function automatic logic aged(input tbl_entry_t ent);
      return ent.valid && ((tcnt - ent.stamp) > m_bb);  // unsigned age
   endfunction

   function automatic dport_t lookup_rule();
      tbl_entry_t ent;
      dport_t     dp;
      ent = m_tbl[m_d[`AL_IDX_BITS-1:0]];
      dp  = '0;
      if (m_d == m_mac)
         dp[4] = 1'b1;                     // frame for the switch
      else if (ent.valid && ent.mac == m_d)
         dp[ent.port] = 1'b1;              // known destination
      else
      begin
         dp[3:0]  = 4'b1111;               // flood
         dp[m_sp] = 1'b0;                  // but not back out the source
      end
      return dp;
   endfunction

   function automatic logic [31:0] expected_read(input logic [6:0] addr);
      case (addr)
         `AL_FRM_D_ADDR_L   : return m_d[31:0];
         `AL_FRM_D_ADDR_U   : return {16'd0, m_d[47:32]};
         `AL_FRM_S_ADDR_L   : return m_s[31:0];
         `AL_FRM_S_ADDR_U   : return {16'd0, m_s[47:32]};
         `AL_S_PORT         : return {30'd0, m_sp};
         `AL_D_PORT         : return {27'd0, m_dport};
         `AL_MAC_ADDR_L     : return m_mac[31:0];
         `AL_MAC_ADDR_U     : return {16'd0, m_mac[47:32]};
         `AL_CUR_TIME       : return tcnt;
         `AL_BB_AGE         : return m_bb;
         `AL_DIV_CLK        : return {24'd0, m_div};
         `AL_STATUS         : return {29'd0, m_reused, inv_now, active};
         `AL_LST_INV_ADDR_L : return m_lst_addr[31:0];
         `AL_LST_INV_ADDR_U : return {16'd0, m_lst_addr[47:32]};
         `AL_LST_INV_PORT   : return {30'd0, m_lst_port};
         default            : return 32'd0;  // command, unmapped
      endcase
   endfunction

   // --------------------
   // all model updates use the values from before the edge
   always @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         m_d        = '0;
         m_s        = '0;
         m_mac      = '0;
         m_sp       = '0;
         m_bb       = `AL_BB_AGE_RST;
         m_div      = '0;
         m_cmd      = CMD_NONE;
         m_dport    = '0;
         m_reused   = 1'b0;
         m_lst_addr = '0;
         m_lst_port = '0;
         m_nrm_addr = '0;
         m_nrm_port = '0;
         chk_ph     = 0;
         age_on     = 1'b0;
         age_i      = '0;
         tcnt       = '0;
         pcnt       = '0;
         pend       = 1'b0;
         errors     = 0;
         checks     = 0;
         for (int i = 0; i < `AL_NUM_ENTRIES; i++)
            m_tbl[i] = '0;
      end
      else
      begin
         active   = (chk_ph != 0) || age_on;
         inv_now  = age_on && aged(m_tbl[age_i]);
         rd_setup = psel && !penable && !pwrite;
         wr_acc   = psel && penable && pwrite;
         if (pend && psel && penable && !pwrite)  // access phase of a read
         begin
            checks++;
            if (prdata !== exp_rd)
            begin
               errors++;
               $display("CHECK FAILED at %0t: read of offset 0x%02h gave 0x%08h, expected 0x%08h",
                        $time, exp_addr, prdata, exp_rd);
            end
            pend = 1'b0;
         end
         if (rd_setup)
         begin
            exp_rd   = expected_read(paddr);
            exp_addr = paddr;
            pend     = 1'b1;
         end
         if (m_reused)  // learning eviction wins
         begin
            m_lst_addr = m_nrm_addr;
            m_lst_port = m_nrm_port;
         end
         else if (inv_now)
         begin
            m_lst_addr = m_tbl[age_i].mac;
            m_lst_port = m_tbl[age_i].port;
         end
         // address checker
         case (chk_ph)
            1 :
            begin
               m_dport = lookup_rule();
               chk_ph  = 2;
            end
            2 :
            begin
               e = m_tbl[m_s[`AL_IDX_BITS-1:0]];
               if (e.valid && e.mac != m_s)
               begin
                  m_reused   = 1'b1;
                  m_nrm_addr = e.mac;
                  m_nrm_port = e.port;
               end
               m_tbl[m_s[`AL_IDX_BITS-1:0]] = '{valid: 1'b1, mac: m_s, port: m_sp,
                                                stamp: tcnt};
               chk_ph = 0;
            end
            default :
            begin
               if (rd_setup && paddr == `AL_STATUS && !active)
                  m_reused = 1'b0;  // status read acks
               if (m_cmd == CMD_CHECK)
                  chk_ph = 1;
            end
         endcase
         // age sweep, one slot per clock
         if (age_on)
         begin
            if (inv_now)
               m_tbl[age_i].valid = 1'b0;
            if (age_i == tbl_idx_t'(`AL_NUM_ENTRIES - 1))
               age_on = 1'b0;
            age_i = age_i + tbl_idx_t'(1);
         end
         else
         begin
            age_i = '0;
            if (m_cmd == CMD_AGE)
               age_on = 1'b1;
         end
         if (m_cmd != CMD_NONE)
            m_cmd = CMD_NONE;
         else if (wr_acc && paddr == `AL_COMMAND && !active &&
                  (pwdata[1:0] == 2'd1 || pwdata[1:0] == 2'd2))
            m_cmd = cmd_t'(pwdata[1:0]);  // busy writes are lost
         if (pcnt >= m_div)  // tick every div+1 clocks
         begin
            pcnt = '0;
            tcnt = tcnt + time_t'(1);
         end
         else
            pcnt = pcnt + 8'd1;
         if (wr_acc)
         begin
            case (paddr)
               `AL_FRM_D_ADDR_L : m_d[31:0]    = pwdata;
               `AL_FRM_D_ADDR_U : m_d[47:32]   = pwdata[15:0];
               `AL_FRM_S_ADDR_L : m_s[31:0]    = pwdata;
               `AL_FRM_S_ADDR_U : m_s[47:32]   = pwdata[15:0];
               `AL_S_PORT       : m_sp         = pwdata[1:0];
               `AL_MAC_ADDR_L   : m_mac[31:0]  = pwdata;
               `AL_MAC_ADDR_U   : m_mac[47:32] = pwdata[15:0];
               `AL_BB_AGE       : m_bb         = pwdata;
               `AL_DIV_CLK      : m_div        = pwdata[7:0];
               default          : ;
            endcase
         end
      end
   end

endmodule

//--- tests/alut_tb.sv
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_tb;

   localparam int POLL_LIMIT = 40;  // status reads before giving up
   localparam int NUM_FRAMES = 24;

   logic        pclk18;
   logic        n_p_reset18;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic [31:0] rd;
   logic [47:0] own_mac;  // switch own address
   int          seed;
   int          timeouts;
   int          mon_errors;
   int          mon_checks;

   alut_top uut (.*);

   alut_monitor mon (.*, .errors(mon_errors), .checks(mon_checks));

   initial
   begin
      pclk18 = 1'b0;
      forever #20 pclk18 = ~pclk18;  // 25 MHz
   end

   // --------------------
   // apb master, inputs change 2 ns after the edge
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      @(posedge pclk18);
      #2;
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk18);
      #2 penable = 1'b1;
      @(posedge pclk18);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(posedge pclk18);
      #2;
      psel   = 1'b1;
      pwrite = 1'b0;
      paddr  = addr;
      @(posedge pclk18);
      #2;
      penable = 1'b1;
      data    = prdata;  // registered in setup, stable here
      @(posedge pclk18);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic finish_run;
      int fails;
      fails = mon_errors + timeouts + uut.i_reg_bank.reg_asserts.fails;
      $display("summary: %0d reads checked, %0d mismatches, %0d assertion failures, %0d timeouts",
               mon_checks, mon_errors, uut.i_reg_bank.reg_asserts.fails, timeouts);
      if (fails == 0 && mon_checks > 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   endtask

   // poll busy bit of status
   task automatic wait_idle;
      int polls;
      polls = 1;
      apb_read(`AL_STATUS, rd);
      while (rd[0] && polls < POLL_LIMIT)
      begin
         apb_read(`AL_STATUS, rd);
         polls++;
      end
      if (rd[0])
      begin
         $display("timeout: checker still busy after %0d status reads at %0t", polls, $time);
         timeouts++;
      end
   endtask

   // --------------------
   // 8 addresses, slots 0..4, last three collide with the first three
   function automatic logic [47:0] pool_mac(input int k);
      return 48'h0250_C3A0_0000 + 48'(k % 5) + (48'(k / 5) << 12);
   endfunction

   task automatic write_readback(input logic [6:0] addr);
      logic [31:0] data;
      data = $random(seed);
      apb_write(addr, data);
      apb_read(addr, rd);
   endtask

   task automatic run_frame(input logic [47:0] d, input logic [47:0] s, input logic [1:0] sp);
      apb_write(`AL_FRM_D_ADDR_L, d[31:0]);
      apb_write(`AL_FRM_D_ADDR_U, {16'd0, d[47:32]});
      apb_write(`AL_FRM_S_ADDR_L, s[31:0]);
      apb_write(`AL_FRM_S_ADDR_U, {16'd0, s[47:32]});
      apb_write(`AL_S_PORT, {30'd0, sp});
      apb_write(`AL_COMMAND, 32'd1);
      wait_idle();                        // first idle read acks reused
      apb_read(`AL_D_PORT, rd);
      apb_read(`AL_LST_INV_ADDR_L, rd);
      apb_read(`AL_LST_INV_ADDR_U, rd);
      apb_read(`AL_LST_INV_PORT, rd);
      apb_read(`AL_STATUS, rd);           // reused gone by now
   endtask

   task automatic random_frame;
      logic [31:0] r1;
      logic [31:0] r2;
      r1 = $random(seed);
      r2 = $random(seed);
      run_frame(pool_mac(int'(r1[2:0])), pool_mac(int'(r2[2:0])), r2[5:4]);
   endtask

   task automatic run_sweep(input logic [31:0] bb_age);
      apb_write(`AL_BB_AGE, bb_age);
      apb_write(`AL_COMMAND, 32'd2);
      wait_idle();
      apb_read(`AL_LST_INV_ADDR_L, rd);
      apb_read(`AL_LST_INV_ADDR_U, rd);
      apb_read(`AL_LST_INV_PORT, rd);
   endtask

   // --------------------
   initial
   begin
      seed        = 67;
      timeouts    = 0;
      n_p_reset18 = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      repeat (8) @(posedge pclk18);
      #2 n_p_reset18 = 1'b1;

      apb_read(`AL_BB_AGE, rd);   // all ones after reset
      apb_read(`AL_COMMAND, rd);
      apb_read(`AL_STATUS, rd);
      apb_read(7'h40, rd);        // unmapped
      apb_read(7'h7C, rd);
      apb_read(7'h01, rd);

      write_readback(`AL_FRM_D_ADDR_L);
      write_readback(`AL_FRM_D_ADDR_U);  // upper 16 bits dropped
      write_readback(`AL_FRM_S_ADDR_L);
      write_readback(`AL_FRM_S_ADDR_U);
      write_readback(`AL_S_PORT);
      write_readback(`AL_MAC_ADDR_L);
      write_readback(`AL_MAC_ADDR_U);
      write_readback(`AL_BB_AGE);
      write_readback(`AL_DIV_CLK);
      write_readback(`AL_D_PORT);        // read only
      write_readback(`AL_CUR_TIME);

      own_mac = pool_mac(7);
      apb_write(`AL_DIV_CLK, 32'd0);
      apb_write(`AL_BB_AGE, `AL_BB_AGE_RST);
      apb_write(`AL_MAC_ADDR_L, own_mac[31:0]);
      apb_write(`AL_MAC_ADDR_U, {16'd0, own_mac[47:32]});

      repeat (NUM_FRAMES) random_frame();

      run_sweep(32'd0);                  // everything ages out
      repeat (8) random_frame();         // lookups flood again

      apb_write(`AL_BB_AGE, `AL_BB_AGE_RST);
      repeat (12) random_frame();
      run_sweep(`AL_BB_AGE_RST);         // nothing ages out
      repeat (8) random_frame();

      apb_read(`AL_CUR_TIME, rd);
      apb_read(`AL_CUR_TIME, rd);

      finish_run();
   end

endmodule
